//--- hw/csr_pkg.sv
package csr_pkg;

    //////////////////////////////////////////////////
    // Pipeline encodings
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_NONE   = 3'd0,  // Not a CSR instruction.
        OP_CSRRW  = 3'd1,
        OP_CSRRS  = 3'd2,
        OP_CSRRC  = 3'd3,
        OP_CSRRWI = 3'd4,  // Immediate forms use rs1 as data.
        OP_CSRRSI = 3'd5,
        OP_CSRRCI = 3'd6
    } operation_type_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } privilege_level_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_operation_e;

    //////////////////////////////////////////////////
    // Command and response
    //////////////////////////////////////////////////

    typedef struct packed {
        logic           read_en;
        logic           write_en;
        csr_operation_e op;
        logic [11:0]    addr;
        logic [31:0]    wdata;
        logic [4:0]     rd;
        logic           exception;  // Decode-time violation.
    } csr_cmd_t;

    typedef struct packed {
        logic        valid;
        logic        rd_we;
        logic [4:0]  rd;
        logic [31:0] rdata;
        logic        exception;
    } csr_rsp_t;

    //////////////////////////////////////////////////
    // CSR map
    //////////////////////////////////////////////////

    localparam logic [11:0] CSR_SSCRATCH = 12'h140;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_CYCLE    = 12'hC00;  // User read-only.

    localparam logic [31:0] CAUSE_ILLEGAL_INSTR = 32'd2;

endpackage

//--- hw/csr_decode.sv
`timescale 1ns/1ps

module csr_decode (
    input  logic [31:0]               first_operand_i,
    input  logic [31:0]               instruction_i,
    input  csr_pkg::operation_type_e  operation_i,
    input  csr_pkg::privilege_level_e privilege_i,
    output csr_pkg::csr_cmd_t         cmd_o
);

    logic [4:0]              rd;
    logic [4:0]              rs1;
    logic [11:0]             addr;
    logic [1:0]              priv_level;
    logic                    rd_en_raw;
    logic                    wr_en_raw;
    logic                    ro_violation;
    logic                    priv_violation;
    logic                    exception;
    logic                    imm_form;
    logic [31:0]             wdata;
    csr_pkg::csr_operation_e op;

    //////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////

    assign rd         = instruction_i[11:7];
    assign rs1        = instruction_i[19:15];
    assign addr       = instruction_i[31:20];
    assign priv_level = privilege_i;

    // Write forms always write; set/clear forms always read.
    always_comb begin
        rd_en_raw = 1'b0;
        wr_en_raw = 1'b0;
        case (operation_i)
            csr_pkg::OP_CSRRW,
            csr_pkg::OP_CSRRWI: begin
                wr_en_raw = 1'b1;
                rd_en_raw = (rd != 5'd0);   // No read side effect on x0.
            end
            csr_pkg::OP_CSRRS,
            csr_pkg::OP_CSRRC,
            csr_pkg::OP_CSRRSI,
            csr_pkg::OP_CSRRCI: begin
                rd_en_raw = 1'b1;
                wr_en_raw = (rs1 != 5'd0);  // rs1 of zero means read only.
            end
            default: begin
                rd_en_raw = 1'b0;
                wr_en_raw = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (operation_i)
            csr_pkg::OP_CSRRW,
            csr_pkg::OP_CSRRWI: op = csr_pkg::CSR_WRITE;
            csr_pkg::OP_CSRRS,
            csr_pkg::OP_CSRRSI: op = csr_pkg::CSR_SET;
            csr_pkg::OP_CSRRC,
            csr_pkg::OP_CSRRCI: op = csr_pkg::CSR_CLEAR;
            default:            op = csr_pkg::CSR_NONE;
        endcase
    end

    assign imm_form = (operation_i == csr_pkg::OP_CSRRWI) ||
                      (operation_i == csr_pkg::OP_CSRRSI) ||
                      (operation_i == csr_pkg::OP_CSRRCI);

    // Immediate is the zero-extended rs1 field.
    assign wdata = imm_form ? {27'b0, rs1} : first_operand_i;

    //////////////////////////////////////////////////
    // Access checks
    //////////////////////////////////////////////////

    assign ro_violation   = wr_en_raw && (addr[11:10] == 2'b11);  // Read-only space.
    assign priv_violation = (rd_en_raw || wr_en_raw) && (priv_level < addr[9:8]);
    assign exception      = ro_violation || priv_violation;

    always_comb begin
        cmd_o.read_en   = rd_en_raw && !exception;  // Masked on violation.
        cmd_o.write_en  = wr_en_raw && !exception;
        cmd_o.op        = op;
        cmd_o.addr      = addr;
        cmd_o.wdata     = wdata;
        cmd_o.rd        = rd;
        cmd_o.exception = exception;
    end

endmodule

//--- hw/csr_file.sv
`timescale 1ns/1ps

module csr_file #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  logic [31:0]       pc_i,
    input  csr_pkg::csr_cmd_t cmd_i,
    output csr_pkg::csr_rsp_t rsp_o
);

    logic [31:0]       sscratch_q;
    logic [31:0]       mtvec_q;
    logic [31:0]       mscratch_q;
    logic [31:0]       mepc_q;
    logic [31:0]       mcause_q;
    logic [31:0]       cycle_q;
    logic [31:0]       old_value;
    logic [31:0]       new_value;
    logic              addr_hit;
    logic              access;
    logic              exception;
    logic              write_fire;
    logic              trap_fire;
    csr_pkg::csr_rsp_t rsp_d;
    csr_pkg::csr_rsp_t rsp_q;

    //////////////////////////////////////////////////
    // Read select
    //////////////////////////////////////////////////

    always_comb begin
        addr_hit  = 1'b1;
        old_value = 32'd0;
        case (cmd_i.addr)
            csr_pkg::CSR_SSCRATCH: old_value = sscratch_q;
            csr_pkg::CSR_MTVEC:    old_value = mtvec_q;
            csr_pkg::CSR_MSCRATCH: old_value = mscratch_q;
            csr_pkg::CSR_MEPC:     old_value = mepc_q;
            csr_pkg::CSR_MCAUSE:   old_value = mcause_q;
            csr_pkg::CSR_CYCLE:    old_value = cycle_q;
            default: begin
                addr_hit  = 1'b0;   // Not implemented here.
                old_value = 32'd0;
            end
        endcase
    end

    assign access    = cmd_i.read_en || cmd_i.write_en;
    assign exception = cmd_i.exception || (access && !addr_hit);

    assign write_fire = valid_i && cmd_i.write_en && !exception;
    assign trap_fire  = valid_i && exception;

    // Read-modify-write result.
    always_comb begin
        case (cmd_i.op)
            csr_pkg::CSR_WRITE: new_value = cmd_i.wdata;
            csr_pkg::CSR_SET:   new_value = old_value | cmd_i.wdata;
            csr_pkg::CSR_CLEAR: new_value = old_value & ~cmd_i.wdata;
            default:            new_value = old_value;
        endcase
    end

    //////////////////////////////////////////////////
    // CSR storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sscratch_q <= 32'd0;
            mtvec_q    <= MTVEC_RESET;
            mscratch_q <= 32'd0;
            mepc_q     <= 32'd0;
            mcause_q   <= 32'd0;
        end else if (trap_fire) begin
            mepc_q   <= pc_i;  // Faulting instruction.
            mcause_q <= csr_pkg::CAUSE_ILLEGAL_INSTR;
        end else if (write_fire) begin
            case (cmd_i.addr)
                csr_pkg::CSR_SSCRATCH: sscratch_q <= new_value;
                csr_pkg::CSR_MTVEC:    mtvec_q    <= new_value;
                csr_pkg::CSR_MSCRATCH: mscratch_q <= new_value;
                csr_pkg::CSR_MEPC:     mepc_q     <= new_value;
                csr_pkg::CSR_MCAUSE:   mcause_q   <= new_value;
                default: begin
                    // Cycle is read-only and never reaches here.
                end
            endcase
        end
    end

    // Free-running counter that ignores valid_i.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cycle_q <= 32'd0;
        end else begin
            cycle_q <= cycle_q + 32'd1;
        end
    end

    //////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////

    always_comb begin
        rsp_d = '0;  // Idle cycles return an empty response.
        if (valid_i) begin
            rsp_d.valid     = 1'b1;
            rsp_d.rd_we     = cmd_i.read_en && !exception;
            rsp_d.rd        = cmd_i.rd;
            rsp_d.rdata     = cmd_i.read_en ? old_value : 32'd0;
            rsp_d.exception = exception;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_o = rsp_q;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // A trapped request only touches mepc and mcause.
    a_trap_keeps_csrs : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        trap_fire |=> ($stable(sscratch_q) && $stable(mtvec_q) && $stable(mscratch_q))
    ) else $error("CSR changed on a trapped request");

    // Fixed one-cycle latency.
    a_rsp_valid_follows : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rst_n_i |=> (rsp_o.valid == $past(valid_i))
    ) else $error("Response valid does not follow request valid");

endmodule

//--- hw/csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  logic [31:0]               pc_i,
    input  logic [31:0]               instruction_i,
    input  logic [31:0]               first_operand_i,
    input  csr_pkg::operation_type_e  operation_i,
    input  csr_pkg::privilege_level_e privilege_i,
    output csr_pkg::csr_rsp_t         rsp_o
);

    csr_pkg::csr_cmd_t cmd;  // Decode to file.

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    csr_decode u_decode (
        .first_operand_i (first_operand_i),
        .instruction_i   (instruction_i),
        .operation_i     (operation_i),
        .privilege_i     (privilege_i),
        .cmd_o           (cmd)
    );

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////

    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .pc_i    (pc_i),
        .cmd_i   (cmd),
        .rsp_o   (rsp_o)
    );

endmodule

//--- tests/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;

    localparam logic [31:0] MTVEC_RESET = 32'h0000_0100;
    localparam int          TIMEOUT     = 3000;  // About 300 requests with a wide margin.

    logic                      clk_i;
    logic                      rst_n_i;
    logic                      valid_i;
    logic [31:0]               pc_i;
    logic [31:0]               instruction_i;
    logic [31:0]               first_operand_i;
    csr_pkg::operation_type_e  operation_i;
    csr_pkg::privilege_level_e privilege_i;
    csr_pkg::csr_rsp_t         rsp_o;

    logic [31:0]       lfsr_state;
    logic [31:0]       sh_sscratch;  // Shadow CSRs.
    logic [31:0]       sh_mtvec;
    logic [31:0]       sh_mscratch;
    logic [31:0]       sh_mepc;
    logic [31:0]       sh_mcause;
    logic [31:0]       next_pc;
    int                cycle_count;
    int                compare_errors;
    int                other_errors;
    csr_pkg::csr_rsp_t exp_q[$];
    int                due_q[$];
    string             name_q[$];

    csr_unit #(
        .MTVEC_RESET (MTVEC_RESET)
    ) UUT (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .valid_i         (valid_i),
        .pc_i            (pc_i),
        .instruction_i   (instruction_i),
        .first_operand_i (first_operand_i),
        .operation_i     (operation_i),
        .privilege_i     (privilege_i),
        .rsp_o           (rsp_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Compare and helpers
    //////////////////////////////////////////////////

    task automatic check_rsp(input string name, input csr_pkg::csr_rsp_t exp,
                             input csr_pkg::csr_rsp_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            compare_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            compare_errors++;
        end
    endtask

    // Galois LFSR stepped once per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [2:0] funct3_of(input csr_pkg::operation_type_e op);
        case (op)
            csr_pkg::OP_CSRRW:  return 3'd1;
            csr_pkg::OP_CSRRS:  return 3'd2;
            csr_pkg::OP_CSRRC:  return 3'd3;
            csr_pkg::OP_CSRRWI: return 3'd5;
            csr_pkg::OP_CSRRSI: return 3'd6;
            csr_pkg::OP_CSRRCI: return 3'd7;
            default:            return 3'd0;
        endcase
    endfunction

    // Reference model of decode and file; updates the shadow CSRs.
    task automatic apply_model(input csr_pkg::operation_type_e op, input logic [4:0] rd,
                               input logic [4:0] rs1, input logic [11:0] addr,
                               input logic [31:0] operand,
                               input csr_pkg::privilege_level_e priv,
                               input logic [31:0] pc, output csr_pkg::csr_rsp_t exp);
        logic        re;
        logic        we;
        logic        exc;
        logic        known;
        logic [31:0] data;
        logic [31:0] old;
        logic [31:0] nv;
        re = 1'b0;
        we = 1'b0;
        if (op == csr_pkg::OP_CSRRW || op == csr_pkg::OP_CSRRWI) begin
            we = 1'b1;
            re = (rd != 0);
        end else if (op != csr_pkg::OP_NONE) begin
            re = 1'b1;
            we = (rs1 != 0);
        end
        data = (op == csr_pkg::OP_CSRRWI || op == csr_pkg::OP_CSRRSI ||
                op == csr_pkg::OP_CSRRCI) ? {27'd0, rs1} : operand;
        exc = (we && addr[11:10] == 2'b11) || ((re || we) && (2'(priv) < addr[9:8]));
        if (exc) begin
            re = 1'b0;
            we = 1'b0;
        end
        known = 1'b1;
        case (addr)
            12'h140: old = sh_sscratch;
            12'h305: old = sh_mtvec;
            12'h340: old = sh_mscratch;
            12'h341: old = sh_mepc;
            12'h342: old = sh_mcause;
            12'hC00: old = 32'd0;  // Counter is never read through the model.
            default: begin
                old   = 32'd0;
                known = 1'b0;
            end
        endcase
        if ((re || we) && !known) exc = 1'b1;
        case (op)
            csr_pkg::OP_CSRRW, csr_pkg::OP_CSRRWI: nv = data;
            csr_pkg::OP_CSRRS, csr_pkg::OP_CSRRSI: nv = old | data;
            default:                               nv = old & ~data;
        endcase
        exp           = '0;
        exp.valid     = 1'b1;
        exp.rd_we     = re && !exc;
        exp.rd        = rd;
        exp.rdata     = re ? old : 32'd0;
        exp.exception = exc;
        if (exc) begin
            sh_mepc   = pc;
            sh_mcause = 32'd2;
        end else if (we) begin
            case (addr)
                12'h140: sh_sscratch = nv;
                12'h305: sh_mtvec    = nv;
                12'h340: sh_mscratch = nv;
                12'h341: sh_mepc     = nv;
                12'h342: sh_mcause   = nv;
                default: ;
            endcase
        end
    endtask

    // Drive one request and queue its expected response.
    task automatic send(input string name, input csr_pkg::operation_type_e op,
                        input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] addr, input logic [31:0] operand,
                        input csr_pkg::privilege_level_e priv);
        csr_pkg::csr_rsp_t exp;
        @(posedge clk_i);
        #0.5;
        next_pc         = next_pc + 32'd4;
        valid_i         = 1'b1;
        pc_i            = next_pc;
        instruction_i   = {addr, rs1, funct3_of(op), rd, 7'h73};
        first_operand_i = operand;
        operation_i     = op;
        privilege_i     = priv;
        apply_model(op, rd, rs1, addr, operand, priv, next_pc, exp);
        exp_q.push_back(exp);
        due_q.push_back(cycle_count + 1);
        name_q.push_back(name);
    endtask

    task automatic idle_cycle(input string name);
        @(posedge clk_i);
        #0.5;
        valid_i     = 1'b0;
        operation_i = csr_pkg::OP_NONE;
        exp_q.push_back('0);
        due_q.push_back(cycle_count + 1);
        name_q.push_back(name);
    endtask

    task automatic drain();
        idle_cycle("drain");
        while (exp_q.size() != 0) @(posedge clk_i);
    endtask

    task automatic read_csr(input string name, input logic [11:0] addr);
        send(name, csr_pkg::OP_CSRRS, 5'd7, 5'd0, addr, 32'd0, csr_pkg::PRIV_M);
    endtask

    always @(negedge clk_i) begin
        if (due_q.size() != 0 && due_q[0] <= cycle_count) begin
            check_rsp(name_q[0], exp_q[0], rsp_o);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
            void'(name_q.pop_front());
        end
    end

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_values();
        check_word("reset_valid", 32'd0, {31'd0, rsp_o.valid});
        read_csr("reset_mtvec", csr_pkg::CSR_MTVEC);
        read_csr("reset_mscratch", csr_pkg::CSR_MSCRATCH);
        drain();
    endtask

    task automatic test_all_forms();
        csr_pkg::operation_type_e op;
        logic [11:0]              addr;
        for (int i = 0; i < 24; i++) begin
            case ((i / 2) % 6)
                0:       op = csr_pkg::OP_CSRRW;
                1:       op = csr_pkg::OP_CSRRS;
                2:       op = csr_pkg::OP_CSRRC;
                3:       op = csr_pkg::OP_CSRRWI;
                4:       op = csr_pkg::OP_CSRRSI;
                default: op = csr_pkg::OP_CSRRCI;
            endcase
            addr = i[0] ? csr_pkg::CSR_SSCRATCH : csr_pkg::CSR_MSCRATCH;
            send("all_forms", op, 5'(rand_bits(4) + 1), 5'(rand_bits(5)), addr,
                 rand_bits(32), csr_pkg::PRIV_M);  // Back to back.
        end
        read_csr("all_forms_mscratch", csr_pkg::CSR_MSCRATCH);
        read_csr("all_forms_sscratch", csr_pkg::CSR_SSCRATCH);
        drain();
    endtask

    task automatic test_suppressed();
        send("rw_rd0", csr_pkg::OP_CSRRW, 5'd0, 5'd3, csr_pkg::CSR_MSCRATCH,
             rand_bits(32), csr_pkg::PRIV_M);
        read_csr("rw_rd0_readback", csr_pkg::CSR_MSCRATCH);
        send("rs_rs1_0", csr_pkg::OP_CSRRS, 5'd4, 5'd0, csr_pkg::CSR_SSCRATCH,
             32'hFFFF_FFFF, csr_pkg::PRIV_M);
        send("rc_rs1_0", csr_pkg::OP_CSRRC, 5'd4, 5'd0, csr_pkg::CSR_MSCRATCH,
             32'hFFFF_FFFF, csr_pkg::PRIV_M);
        read_csr("suppressed_ss", csr_pkg::CSR_SSCRATCH);
        read_csr("suppressed_ms", csr_pkg::CSR_MSCRATCH);
        drain();
    endtask

    // Trap, then confirm mepc, mcause and the target.
    task automatic trap_check(input string name, input csr_pkg::operation_type_e op,
                              input logic [11:0] addr, input csr_pkg::privilege_level_e priv,
                              input logic read_target);
        send(name, op, 5'd9, 5'd5, addr, rand_bits(32), priv);
        read_csr({name, "_mepc"}, csr_pkg::CSR_MEPC);
        read_csr({name, "_mcause"}, csr_pkg::CSR_MCAUSE);
        if (read_target) read_csr({name, "_target"}, addr);
        drain();
    endtask

    task automatic test_violations();
        trap_check("cycle_write", csr_pkg::OP_CSRRW, csr_pkg::CSR_CYCLE,
                   csr_pkg::PRIV_M, 1'b0);
        trap_check("cycle_set", csr_pkg::OP_CSRRSI, csr_pkg::CSR_CYCLE,
                   csr_pkg::PRIV_U, 1'b0);
        trap_check("mscratch_s", csr_pkg::OP_CSRRS, csr_pkg::CSR_MSCRATCH,
                   csr_pkg::PRIV_S, 1'b1);
        trap_check("mscratch_u", csr_pkg::OP_CSRRW, csr_pkg::CSR_MSCRATCH,
                   csr_pkg::PRIV_U, 1'b1);
        trap_check("sscratch_u", csr_pkg::OP_CSRRC, csr_pkg::CSR_SSCRATCH,
                   csr_pkg::PRIV_U, 1'b1);
    endtask

    task automatic test_unimplemented();
        trap_check("unimpl_rs", csr_pkg::OP_CSRRS, 12'h7C0, csr_pkg::PRIV_M, 1'b0);
        trap_check("unimpl_rw", csr_pkg::OP_CSRRW, 12'h7C0, csr_pkg::PRIV_M, 1'b0);
    endtask

    task automatic read_cycle(output logic [31:0] value);
        @(posedge clk_i);
        #0.5;
        valid_i       = 1'b1;
        instruction_i = {csr_pkg::CSR_CYCLE, 5'd0, 3'd2, 5'd6, 7'h73};
        operation_i   = csr_pkg::OP_CSRRS;
        privilege_i   = csr_pkg::PRIV_M;
        @(posedge clk_i);
        #0.5;
        valid_i     = 1'b0;
        operation_i = csr_pkg::OP_NONE;
        #1;
        check_word("cycle_rd_we", 32'd1, {31'd0, rsp_o.rd_we});
        value = rsp_o.rdata;
    endtask

    task automatic test_cycle_counter();
        logic [31:0] first;
        logic [31:0] second;
        read_cycle(first);
        idle_cycle("cycle_idle");
        idle_cycle("cycle_idle");
        idle_cycle("cycle_idle");
        drain();
        read_cycle(second);
        if (second <= first) begin
            $display("Cycle counter did not increase: %h then %h", first, second);
            other_errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        valid_i         = 1'b0;
        pc_i            = 32'd0;
        instruction_i   = 32'd0;
        first_operand_i = 32'd0;
        operation_i     = csr_pkg::OP_NONE;
        privilege_i     = csr_pkg::PRIV_M;
        lfsr_state      = 32'h87af3188;
        sh_sscratch     = 32'd0;
        sh_mtvec        = MTVEC_RESET;
        sh_mscratch     = 32'd0;
        sh_mepc         = 32'd0;
        sh_mcause       = 32'd0;
        next_pc         = 32'h0000_1000;
        cycle_count     = 0;
        compare_errors  = 0;
        other_errors    = 0;
        repeat (2) @(posedge clk_i);
        #0.5;
        rst_n_i = 1'b1;
        #1;
        test_reset_values();
        test_all_forms();
        test_suppressed();
        test_violations();
        test_unimplemented();
        test_cycle_counter();
        drain();
        $display("Errors: %0d compare, %0d other", compare_errors, other_errors);
        if (compare_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_file.sv
hw/csr_unit.sv
tests/csr_unit_tb.sv

//--- Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module csr_unit

sim:
	verilator --binary --timing --assert -f flist.f --top-module csr_unit_tb \
		-o csr_sim
	./obj_dir/csr_sim | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir
